//--- Bender.yml
package:
  name: rr_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rr_types_pkg.sv
      - common/rr_bus_pkg.sv
      - hdl/record/rr_channel_monitor.sv
      - hdl/record/rr_logging_group.sv
      - hdl/rr_log_store.sv
      - hdl/replay/rr_replay_ungroup.sv
      - hdl/replay/rr_channel_replayer.sv
      - hdl/rr_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/rr_unit_sva.sv
      - verification/rr_unit_tb.sv

//--- common/rr_bus_pkg.sv
// record/replay logging bus types
// per-channel logging buses, the grouped log entry and its word view

`include "rr_config.svh"

package rr_bus_pkg;

  typedef struct packed {
    logic                        logb_valid;
    logic [`RR_CHAN_A_WIDTH-1:0] logb_data;
    logic                        loge_valid;
  } rr_logbus_a_t;

  typedef struct packed {
    logic                        logb_valid;
    logic [`RR_CHAN_B_WIDTH-1:0] logb_data;
    logic                        loge_valid;
  } rr_logbus_b_t;

  // bit 0 of each valid vector is channel A
  typedef struct packed {
    logic [1:0]                  loge_valid;
    logic [1:0]                  logb_valid;
    logic [`RR_CHAN_B_WIDTH-1:0] data_b;
    logic [`RR_CHAN_A_WIDTH-1:0] data_a;
  } rr_log_entry_t;

  localparam int RR_LOG_WIDTH = $bits(rr_log_entry_t);

  typedef union packed {
    rr_log_entry_t           entry;
    logic [RR_LOG_WIDTH-1:0] raw;
  } rr_log_word_u;

  typedef struct packed {
    logic hi;
    logic lo;
  } rr_almful_t;

endpackage

//--- common/rr_config.svh
// record/replay unit configuration
// channel widths, log buffer depth and almost-full thresholds

`ifndef RR_CONFIG_SVH
`define RR_CONFIG_SVH

// payload widths of the two channels
`define RR_CHAN_A_WIDTH 8
`define RR_CHAN_B_WIDTH 16

// log buffer depth in words
`define RR_LOG_DEPTH 16

// back-pressure level, keep at or below depth minus 2
`define RR_ALMFUL_HI 12

// warning level
`define RR_ALMFUL_LO 4

`endif

//--- common/rr_types_pkg.sv
// record/replay stream types
// beat types of the two channels and the operating mode

`include "rr_config.svh"

package rr_types_pkg;

  typedef enum logic {
    RR_RECORD = 1'b0,
    RR_REPLAY = 1'b1
  } rr_mode_e;

  // channel A beat, 9 bits
  typedef struct packed {
    logic [`RR_CHAN_A_WIDTH-1:0] data;
    logic                        last;
  } rr_beat_a_t;

  // channel B beat, 17 bits
  typedef struct packed {
    logic [`RR_CHAN_B_WIDTH-1:0] data;
    logic                        last;
  } rr_beat_b_t;

endpackage

//--- hdl/record/rr_channel_monitor.sv
// record-side channel monitor
// passes the stream through in record mode and reports accepted beats

module rr_channel_monitor
  import rr_types_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  rr_mode_e         mode,
  input  logic             almful_hi,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_last,
  output logic             pass_valid,
  input  logic             pass_ready,
  output logic [WIDTH-1:0] pass_data,
  output logic             pass_last,
  output logic [WIDTH+1:0] logbus
);

  logic recording;
  logic accept;

  // stall the channel while the log is nearly full
  assign recording = (mode == RR_RECORD) && !almful_hi;

  assign pass_valid = recording && in_valid;
  assign pass_data  = in_data;
  assign pass_last  = in_last;
  assign in_ready   = recording && pass_ready;

  assign accept = in_valid && in_ready;

  // {logb_valid, logb_data, loge_valid}
  assign logbus = {accept, in_data, accept && in_last};

endmodule

//--- hdl/record/rr_logging_group.sv
// logging bus group for two channels
// registers both logging buses into one log word and pushes it

module rr_logging_group
  import rr_bus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  rr_logbus_a_t logbus_a,
  input  rr_logbus_b_t logbus_b,
  input  rr_almful_t   almful,
  output logic         almful_hi_a,
  output logic         almful_hi_b,
  output logic         push,
  output rr_log_word_u word
);

  rr_log_entry_t entry_d;

  // channel A takes the low positions
  always_comb begin
    entry_d.loge_valid = {logbus_b.loge_valid, logbus_a.loge_valid};
    entry_d.logb_valid = {logbus_b.logb_valid, logbus_a.logb_valid};
    entry_d.data_b     = logbus_b.logb_data;
    entry_d.data_a     = logbus_a.logb_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      push <= 1'b0;
    end else begin
      push <= |entry_d.logb_valid;
    end
  end

  always_ff @(posedge clk) begin
    word.entry <= entry_d;
  end

  // both channels see the same back-pressure
  assign almful_hi_a = almful.hi;
  assign almful_hi_b = almful.hi;

endmodule

//--- hdl/replay/rr_channel_replayer.sv
// channel replayer
// holds one replayed beat on the output until the sink takes it

module rr_channel_replayer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic [WIDTH-1:0] load_data,
  input  logic             load_last,
  output logic             busy,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_last
);

  logic             valid_q;
  logic [WIDTH-1:0] data_q;
  logic             last_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (valid_q && out_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= load_data;
      last_q <= load_last;
    end
  end

  assign busy      = valid_q;
  assign out_valid = valid_q;
  assign out_data  = data_q;
  assign out_last  = last_q;

endmodule

//--- hdl/replay/rr_replay_ungroup.sv
// replay ungroup for two channels
// hands the head word's beats to the replayers, pops once both are done

module rr_replay_ungroup
  import rr_types_pkg::*;
  import rr_bus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  rr_mode_e     mode,
  input  logic         head_valid,
  output logic         head_ready,
  input  rr_log_word_u head_word,
  output logic         load_a,
  output rr_beat_a_t   beat_a,
  input  logic         busy_a,
  output logic         load_b,
  output rr_beat_b_t   beat_b,
  input  logic         busy_b
);

  rr_log_entry_t head;
  logic          active;
  logic [1:0]    loaded_q;
  logic [1:0]    pending;

  assign head    = head_word.entry;
  assign active  = (mode == RR_REPLAY) && head_valid;
  assign pending = head.logb_valid & ~loaded_q;

  // one beat per channel per word
  assign load_a = active && pending[0] && !busy_a;
  assign load_b = active && pending[1] && !busy_b;

  assign beat_a.data = head.data_a;
  assign beat_a.last = head.loge_valid[0];
  assign beat_b.data = head.data_b;
  assign beat_b.last = head.loge_valid[1];

  // pop only after both replayers have drained this word
  assign head_ready = active && (pending == 2'b00) && !busy_a && !busy_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      loaded_q <= 2'b00;
    end else if (head_ready) begin
      loaded_q <= 2'b00;
    end else begin
      loaded_q <= loaded_q | {load_b, load_a};
    end
  end

endmodule

//--- hdl/rr_log_store.sv
// log word buffer
// circular FIFO with occupancy and two almost-full levels

`include "rr_config.svh"

module rr_log_store
  import rr_bus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  rr_log_word_u push_word,
  output logic         head_valid,
  input  logic         head_ready,
  output rr_log_word_u head_word,
  output rr_almful_t   almful
);

  localparam int DEPTH = `RR_LOG_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [RR_LOG_WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count == CNT_W'(DEPTH));
  assign wr_en = push && !full;
  assign rd_en = head_valid && head_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_word.raw;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_valid    = (count != '0);
  assign head_word.raw = mem[rd_ptr];

  // levels follow the registered count
  assign almful.hi = (count >= CNT_W'(`RR_ALMFUL_HI));
  assign almful.lo = (count >= CNT_W'(`RR_ALMFUL_LO));

endmodule

//--- hdl/rr_unit_top.sv
// two-channel record/replay unit
// records accepted beats into a log buffer and replays them per channel

`include "rr_config.svh"

module rr_unit_top
  import rr_types_pkg::*;
  import rr_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rr_mode_e   mode,
  input  logic       a_in_valid,
  output logic       a_in_ready,
  input  rr_beat_a_t a_in_beat,
  input  logic       b_in_valid,
  output logic       b_in_ready,
  input  rr_beat_b_t b_in_beat,
  output logic       a_out_valid,
  input  logic       a_out_ready,
  output rr_beat_a_t a_out_beat,
  output logic       b_out_valid,
  input  logic       b_out_ready,
  output rr_beat_b_t b_out_beat,
  output logic       log_warn
);

  logic         record;
  logic         pass_a_valid;
  logic         pass_b_valid;
  rr_beat_a_t   pass_a_beat;
  rr_beat_b_t   pass_b_beat;
  rr_logbus_a_t logbus_a;
  rr_logbus_b_t logbus_b;
  logic         almful_hi_a;
  logic         almful_hi_b;
  rr_almful_t   almful;
  logic         push;
  rr_log_word_u push_word;
  logic         head_valid;
  logic         head_ready;
  rr_log_word_u head_word;
  logic         load_a;
  logic         load_b;
  rr_beat_a_t   load_beat_a;
  rr_beat_b_t   load_beat_b;
  logic         busy_a;
  logic         busy_b;
  logic         rep_a_valid;
  logic         rep_b_valid;
  rr_beat_a_t   rep_a_beat;
  rr_beat_b_t   rep_b_beat;

  assign record = (mode == RR_RECORD);

  rr_channel_monitor #(
    .WIDTH(`RR_CHAN_A_WIDTH)
  ) u_monitor_a (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .almful_hi (almful_hi_a),
    .in_valid  (a_in_valid),
    .in_ready  (a_in_ready),
    .in_data   (a_in_beat.data),
    .in_last   (a_in_beat.last),
    .pass_valid(pass_a_valid),
    .pass_ready(record && a_out_ready),
    .pass_data (pass_a_beat.data),
    .pass_last (pass_a_beat.last),
    .logbus    (logbus_a)
  );

  rr_channel_monitor #(
    .WIDTH(`RR_CHAN_B_WIDTH)
  ) u_monitor_b (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .almful_hi (almful_hi_b),
    .in_valid  (b_in_valid),
    .in_ready  (b_in_ready),
    .in_data   (b_in_beat.data),
    .in_last   (b_in_beat.last),
    .pass_valid(pass_b_valid),
    .pass_ready(record && b_out_ready),
    .pass_data (pass_b_beat.data),
    .pass_last (pass_b_beat.last),
    .logbus    (logbus_b)
  );

  rr_logging_group u_group (
    .clk        (clk),
    .reset      (reset),
    .logbus_a   (logbus_a),
    .logbus_b   (logbus_b),
    .almful     (almful),
    .almful_hi_a(almful_hi_a),
    .almful_hi_b(almful_hi_b),
    .push       (push),
    .word       (push_word)
  );

  rr_log_store u_store (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_word (push_word),
    .head_valid(head_valid),
    .head_ready(head_ready),
    .head_word (head_word),
    .almful    (almful)
  );

  rr_replay_ungroup u_ungroup (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .head_valid(head_valid),
    .head_ready(head_ready),
    .head_word (head_word),
    .load_a    (load_a),
    .beat_a    (load_beat_a),
    .busy_a    (busy_a),
    .load_b    (load_b),
    .beat_b    (load_beat_b),
    .busy_b    (busy_b)
  );

  rr_channel_replayer #(
    .WIDTH(`RR_CHAN_A_WIDTH)
  ) u_replayer_a (
    .clk      (clk),
    .reset    (reset),
    .load     (load_a),
    .load_data(load_beat_a.data),
    .load_last(load_beat_a.last),
    .busy     (busy_a),
    .out_valid(rep_a_valid),
    .out_ready(!record && a_out_ready),
    .out_data (rep_a_beat.data),
    .out_last (rep_a_beat.last)
  );

  rr_channel_replayer #(
    .WIDTH(`RR_CHAN_B_WIDTH)
  ) u_replayer_b (
    .clk      (clk),
    .reset    (reset),
    .load     (load_b),
    .load_data(load_beat_b.data),
    .load_last(load_beat_b.last),
    .busy     (busy_b),
    .out_valid(rep_b_valid),
    .out_ready(!record && b_out_ready),
    .out_data (rep_b_beat.data),
    .out_last (rep_b_beat.last)
  );

  // output source follows the mode
  assign a_out_valid = record ? pass_a_valid : rep_a_valid;
  assign a_out_beat  = record ? pass_a_beat  : rep_a_beat;
  assign b_out_valid = record ? pass_b_valid : rep_b_valid;
  assign b_out_beat  = record ? pass_b_beat  : rep_b_beat;

  assign log_warn = almful.lo;

endmodule

//--- verification/rr_unit_sva.sv
// buffer and replayer handshake checks
// bound into the log store and both channel replayers

module rr_unit_sva (
  input logic        clk,
  input logic        reset,
  input logic        push,
  input logic        full,
  input logic        pop,
  input logic        empty,
  input logic        load,
  input logic        busy,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] out_payload
);

  push_not_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
    else $error("log word pushed into a full buffer");

  pop_not_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
    else $error("log word popped from an empty buffer");

  // held beat stays put until the sink takes it
  out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_payload))
    else $error("replayed beat dropped or changed before acceptance");

  load_not_busy: assert property (@(posedge clk) disable iff (reset) !(load && busy))
    else $error("replayer loaded while still holding a beat");

endmodule

bind rr_log_store rr_unit_sva u_store_sva (
  .clk        (clk),
  .reset      (reset),
  .push       (push),
  .full       (full),
  .pop        (head_ready),
  .empty      (!head_valid),
  .load       (1'b0),
  .busy       (1'b0),
  .out_valid  (1'b0),
  .out_ready  (1'b0),
  .out_payload(32'h0)
);

bind rr_channel_replayer rr_unit_sva u_replayer_sva (
  .clk        (clk),
  .reset      (reset),
  .push       (1'b0),
  .full       (1'b0),
  .pop        (1'b0),
  .empty      (1'b0),
  .load       (load),
  .busy       (busy),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_payload(32'({out_last, out_data}))
);

//--- verification/rr_unit_tb.sv
// testbench for the two-channel record/replay unit
// records random traffic, replays it and checks order, grouping and levels

`include "rr_config.svh"

module rr_unit_tb
  import rr_types_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 1000;

  logic       clk;
  logic       reset;
  rr_mode_e   mode;
  logic       a_in_valid;
  logic       a_in_ready;
  rr_beat_a_t a_in_beat;
  logic       b_in_valid;
  logic       b_in_ready;
  rr_beat_b_t b_in_beat;
  logic       a_out_valid;
  logic       a_out_ready;
  rr_beat_a_t a_out_beat;
  logic       b_out_valid;
  logic       b_out_ready;
  rr_beat_b_t b_out_beat;
  logic       log_warn;

  // model of the recorded stream, one queue per channel with word index
  rr_beat_a_t exp_a_q[$];
  rr_beat_b_t exp_b_q[$];
  int         word_a_q[$];
  int         word_b_q[$];
  int         word_seq;
  int         model_words;

  int checks;
  int errors;
  int tests;
  int checks_at_start;
  int errors_at_start;

  rr_unit_top u_rr_unit_top (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .a_in_valid (a_in_valid),
    .a_in_ready (a_in_ready),
    .a_in_beat  (a_in_beat),
    .b_in_valid (b_in_valid),
    .b_in_ready (b_in_ready),
    .b_in_beat  (b_in_beat),
    .a_out_valid(a_out_valid),
    .a_out_ready(a_out_ready),
    .a_out_beat (a_out_beat),
    .b_out_valid(b_out_valid),
    .b_out_ready(b_out_ready),
    .b_out_beat (b_out_beat),
    .log_warn   (log_warn)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // grouping rule: beats accepted in one cycle share one log word
  function automatic void model_accept(input bit hs_a, input rr_beat_a_t beat_a,
                                       input bit hs_b, input rr_beat_b_t beat_b);
    if (hs_a) begin
      exp_a_q.push_back(beat_a);
      word_a_q.push_back(word_seq);
    end
    if (hs_b) begin
      exp_b_q.push_back(beat_b);
      word_b_q.push_back(word_seq);
    end
    if (hs_a || hs_b) begin
      word_seq++;
      model_words++;
    end
  endfunction

  // {warning level, input ready with the sink ready}
  function automatic logic [1:0] expected_levels(input int words);
    return {words >= `RR_ALMFUL_LO, words < `RR_ALMFUL_HI};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic close_test(input string name);
    tests++;
    $display("test %0d %s done: %0d checks, %0d errors", tests, name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    exp_a_q.delete();
    exp_b_q.delete();
    word_a_q.delete();
    word_b_q.delete();
    model_words = 0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // random valid pattern, each source holds its beat until accepted
  task automatic drive_traffic(input int n_a, input int n_b, input int pct);
    int sent_a;
    int sent_b;
    int cycles;
    bit hs_a;
    bit hs_b;
    sent_a = 0;
    sent_b = 0;
    cycles = 0;
    while (sent_a < n_a || sent_b < n_b) begin
      @(negedge clk);
      hs_a = a_in_valid && a_in_ready;
      hs_b = b_in_valid && b_in_ready;
      if (hs_a) sent_a++;
      if (hs_b) sent_b++;
      @(posedge clk);
      #2;
      if (hs_a || !a_in_valid) begin
        a_in_valid = 1'b0;
        if (sent_a < n_a && ($urandom % 100) < pct) begin
          a_in_valid     = 1'b1;
          a_in_beat.data = `RR_CHAN_A_WIDTH'($urandom);
          a_in_beat.last = 1'($urandom);
        end
      end
      if (hs_b || !b_in_valid) begin
        b_in_valid = 1'b0;
        if (sent_b < n_b && ($urandom % 100) < pct) begin
          b_in_valid     = 1'b1;
          b_in_beat.data = `RR_CHAN_B_WIDTH'($urandom);
          b_in_beat.last = 1'($urandom);
        end
      end
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("record traffic to be accepted");
    end
  endtask

  task automatic send_one_a();
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    #2;
    a_in_valid     = 1'b1;
    a_in_beat.data = `RR_CHAN_A_WIDTH'($urandom);
    a_in_beat.last = 1'($urandom);
    while (!done) begin
      @(negedge clk);
      done = a_in_valid && a_in_ready;
      cycles++;
      if (!done && cycles > TIMEOUT_CYCLES) report_timeout("a channel A handshake");
    end
    @(posedge clk);
    #2;
    a_in_valid = 1'b0;
  endtask

  // replay until the model is empty, then outputs must stay idle
  task automatic replay_and_drain(input int pct_a, input int pct_b);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    mode = RR_REPLAY;
    while (exp_a_q.size() != 0 || exp_b_q.size() != 0 || a_out_valid || b_out_valid) begin
      @(posedge clk);
      #2;
      a_out_ready = ($urandom % 100) < pct_a;
      b_out_ready = ($urandom % 100) < pct_b;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("the replay to drain");
    end
    repeat (8) begin
      @(negedge clk);
      check_value("a_out_valid", a_out_valid, 1'b0);
      check_value("b_out_valid", b_out_valid, 1'b0);
    end
    @(posedge clk);
    #2;
    mode        = RR_RECORD;
    a_out_ready = 1'b1;
    b_out_ready = 1'b1;
    model_words = 0;
  endtask

  // compare process, sampled mid-cycle when every signal is settled
  always @(negedge clk) begin
    bit hs_a;
    bit hs_b;
    if (!reset) begin
      hs_a = a_out_valid && a_out_ready;
      hs_b = b_out_valid && b_out_ready;
      if (mode == RR_RECORD) begin
        check_value("a_out handshake", hs_a, a_in_valid && a_in_ready);
        check_value("b_out handshake", hs_b, b_in_valid && b_in_ready);
        if (hs_a) check_value("a_out_beat", a_out_beat, a_in_beat);
        if (hs_b) check_value("b_out_beat", b_out_beat, b_in_beat);
        model_accept(a_in_valid && a_in_ready, a_in_beat, b_in_valid && b_in_ready, b_in_beat);
      end else begin
        if (hs_a) begin
          checks++;
          assert (exp_a_q.size() != 0) else begin
            $display("unexpected beat on channel A at %0t with nothing left to replay", $time);
            errors++;
          end
          if (exp_a_q.size() != 0) begin
            check_value("a_out_beat", a_out_beat, exp_a_q[0]);
            if (word_b_q.size() != 0) begin
              checks++;
              assert (word_b_q[0] >= word_a_q[0]) else begin
                $display("channel A replayed word %0d at %0t before channel B finished word %0d",
                         word_a_q[0], $time, word_b_q[0]);
                errors++;
              end
            end
          end
        end
        if (hs_b) begin
          checks++;
          assert (exp_b_q.size() != 0) else begin
            $display("unexpected beat on channel B at %0t with nothing left to replay", $time);
            errors++;
          end
          if (exp_b_q.size() != 0) begin
            check_value("b_out_beat", b_out_beat, exp_b_q[0]);
            if (word_a_q.size() != 0) begin
              checks++;
              assert (word_a_q[0] >= word_b_q[0]) else begin
                $display("channel B replayed word %0d at %0t before channel A finished word %0d",
                         word_b_q[0], $time, word_a_q[0]);
                errors++;
              end
            end
          end
        end
        if (hs_a && exp_a_q.size() != 0) begin
          void'(exp_a_q.pop_front());
          void'(word_a_q.pop_front());
        end
        if (hs_b && exp_b_q.size() != 0) begin
          void'(exp_b_q.pop_front());
          void'(word_b_q.pop_front());
        end
      end
    end
  end

  initial begin
    logic [1:0]  lv;
    int          i;
    void'($urandom(32'heabd));
    checks      = 0;
    errors      = 0;
    tests       = 0;
    word_seq    = 0;
    mode        = RR_RECORD;
    a_in_valid  = 1'b0;
    a_in_beat   = '0;
    b_in_valid  = 1'b0;
    b_in_beat   = '0;
    a_out_ready = 1'b1;
    b_out_ready = 1'b1;
    apply_reset();

    start_test();
    drive_traffic(5, 5, 60);
    close_test("record pass-through");

    start_test();
    replay_and_drain(100, 100);
    close_test("replay order");

    // channel A alone, flags follow the word count two cycles later
    start_test();
    for (i = 0; i < `RR_ALMFUL_HI; i++) begin
      send_one_a();
      repeat (2) @(negedge clk);
      lv = expected_levels(model_words);
      check_value("log_warn", log_warn, lv[1]);
      check_value("a_in_ready", a_in_ready, lv[0]);
    end
    replay_and_drain(100, 100);
    close_test("back-pressure");

    start_test();
    drive_traffic(3, 3, 100);
    repeat (2) @(negedge clk);
    lv = expected_levels(model_words);
    check_value("log_warn", log_warn, lv[1]);
    drive_traffic(2, 1, 50);
    replay_and_drain(100, 30);
    close_test("grouped entries");

    start_test();
    drive_traffic(5, 5, 60);
    replay_and_drain(50, 50);
    close_test("sink stalls");

    // reset while both channels are streaming
    start_test();
    @(posedge clk);
    #2;
    a_in_valid     = 1'b1;
    a_in_beat.data = `RR_CHAN_A_WIDTH'($urandom);
    b_in_valid     = 1'b1;
    b_in_beat.data = `RR_CHAN_B_WIDTH'($urandom);
    repeat (6) @(posedge clk);
    #2;
    apply_reset();
    a_in_valid  = 1'b0;
    b_in_valid  = 1'b0;
    a_out_ready = 1'b0;
    b_out_ready = 1'b0;
    @(negedge clk);
    check_value("a_in_ready", a_in_ready, 1'b0);
    check_value("b_in_ready", b_in_ready, 1'b0);
    check_value("a_out_valid", a_out_valid, 1'b0);
    check_value("b_out_valid", b_out_valid, 1'b0);
    check_value("log_warn", log_warn, 1'b0);
    @(posedge clk);
    #2;
    mode        = RR_REPLAY;
    a_out_ready = 1'b1;
    b_out_ready = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_value("a_out_valid", a_out_valid, 1'b0);
      check_value("b_out_valid", b_out_valid, 1'b0);
    end
    close_test("reset");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/rr_types_pkg.sv
common/rr_bus_pkg.sv
hdl/record/rr_channel_monitor.sv
hdl/record/rr_logging_group.sv
hdl/rr_log_store.sv
hdl/replay/rr_replay_ungroup.sv
hdl/replay/rr_channel_replayer.sv
hdl/rr_unit_top.sv
verification/rr_unit_sva.sv
verification/rr_unit_tb.sv
